// File: hdl/bus_pkg.sv
package bus_pkg;

    // System address width
    localparam int addr_width = 16;

    // Request from the core
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  write_en;
        logic [7:0]            wdata;
    } bus_req_t;

    // Response back to the core
    typedef struct packed {
        logic [7:0] rdata;
        logic       write_ack;
    } bus_rsp_t;

    // Shared peripheral bus, sel is high for exactly one cycle per access
    typedef struct packed {
        logic                  sel;
        logic [addr_width-1:0] addr;
        logic                  write_en;
        logic [7:0]            wdata;
    } periph_bus_t;

endpackage

// File: hdl/io_pkg.sv
package io_pkg;

    // Byte registers per peripheral window
    localparam int io_window = 8;

    // GPIO pin count
    localparam int pin_width = 16;

    // GPIO register offsets
    localparam logic [2:0] reg_gpo_lo  = 3'd0;
    localparam logic [2:0] reg_gpo_hi  = 3'd1;
    localparam logic [2:0] reg_gpi_lo  = 3'd2;
    localparam logic [2:0] reg_gpi_hi  = 3'd3;
    localparam logic [2:0] reg_rise_lo = 3'd4;
    localparam logic [2:0] reg_rise_hi = 3'd5;
    localparam logic [2:0] reg_fall_lo = 3'd6;
    localparam logic [2:0] reg_fall_hi = 3'd7;

    // Timer register offsets, 5 to 7 unused
    localparam logic [2:0] reg_reload_lo = 3'd0;
    localparam logic [2:0] reg_reload_hi = 3'd1;
    localparam logic [2:0] reg_ctrl      = 3'd2;
    localparam logic [2:0] reg_count_lo  = 3'd3;
    localparam logic [2:0] reg_count_hi  = 3'd4;

endpackage

// File: hdl/rw_register.sv
`timescale 1ns/10ps

module rw_register #(
    parameter logic [2:0] reg_addr    = 3'd0,
    parameter logic [7:0] reset_value = 8'h00
) (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::periph_bus_t bus,
    input  logic                 hit,
    output logic [7:0]           rdata,
    output logic [7:0]           value
);

    logic addressed;

    // Window hit, strobe and own offset
    assign addressed = hit && bus.sel && (bus.addr[2:0] == reg_addr);

    always_ff @(posedge clk) begin
        if (!reset) begin
            value <= reset_value;
        end else if (addressed && bus.write_en) begin
            value <= bus.wdata;
        end
    end

    // Zero unless this register is being read
    assign rdata = (addressed && !bus.write_en) ? value : 8'h00;

endmodule

// File: hdl/gpio.sv
`timescale 1ns/10ps

module gpio #(
    parameter logic [bus_pkg::addr_width-1:0] base_addr = 16'hFF08
) (
    input  logic                       clk,
    input  logic                       reset,
    input  bus_pkg::periph_bus_t       bus,
    output logic [7:0]                 rdata,
    input  logic [io_pkg::pin_width-1:0] gpi,
    output logic [io_pkg::pin_width-1:0] gpo,
    output logic                       irq
);

    import bus_pkg::*;
    import io_pkg::*;

    logic [addr_width-1:0] offset;
    logic                  hit;
    logic                  rd;
    logic [pin_width-1:0]  prev_gpi;
    logic [pin_width-1:0]  rise_mask;
    logic [pin_width-1:0]  fall_mask;
    logic [pin_width-1:0]  rising;
    logic [pin_width-1:0]  falling;
    logic [7:0]            rd_gpo_lo;
    logic [7:0]            rd_gpo_hi;
    logic [7:0]            rd_gpi_lo;
    logic [7:0]            rd_gpi_hi;
    logic [7:0]            rd_rise_lo;
    logic [7:0]            rd_rise_hi;
    logic [7:0]            rd_fall_lo;
    logic [7:0]            rd_fall_hi;

    // Window decode
    assign offset = bus.addr - base_addr;
    assign hit    = offset < addr_width'(io_window);
    assign rd     = hit && bus.sel && !bus.write_en;

    rw_register #(.reg_addr(reg_gpo_lo), .reset_value(8'h00)) gpo_lo_i (
        .clk, .reset, .bus, .hit, .rdata(rd_gpo_lo), .value(gpo[7:0])
    );
    rw_register #(.reg_addr(reg_gpo_hi), .reset_value(8'h00)) gpo_hi_i (
        .clk, .reset, .bus, .hit, .rdata(rd_gpo_hi), .value(gpo[15:8])
    );
    rw_register #(.reg_addr(reg_rise_lo), .reset_value(8'h00)) rise_lo_i (
        .clk, .reset, .bus, .hit, .rdata(rd_rise_lo), .value(rise_mask[7:0])
    );
    rw_register #(.reg_addr(reg_rise_hi), .reset_value(8'h00)) rise_hi_i (
        .clk, .reset, .bus, .hit, .rdata(rd_rise_hi), .value(rise_mask[15:8])
    );
    rw_register #(.reg_addr(reg_fall_lo), .reset_value(8'h00)) fall_lo_i (
        .clk, .reset, .bus, .hit, .rdata(rd_fall_lo), .value(fall_mask[7:0])
    );
    rw_register #(.reg_addr(reg_fall_hi), .reset_value(8'h00)) fall_hi_i (
        .clk, .reset, .bus, .hit, .rdata(rd_fall_hi), .value(fall_mask[15:8])
    );

    // Input bytes are read straight from the pins
    assign rd_gpi_lo = (rd && bus.addr[2:0] == reg_gpi_lo) ? gpi[7:0] : 8'h00;
    assign rd_gpi_hi = (rd && bus.addr[2:0] == reg_gpi_hi) ? gpi[15:8] : 8'h00;

    assign rdata = rd_gpo_lo | rd_gpo_hi | rd_gpi_lo | rd_gpi_hi
                 | rd_rise_lo | rd_rise_hi | rd_fall_lo | rd_fall_hi;

    always_ff @(posedge clk) begin
        if (!reset) begin
            prev_gpi <= '0;
        end else begin
            prev_gpi <= gpi;
        end
    end

    // Per-bit edges
    assign rising  = gpi & ~prev_gpi;
    assign falling = ~gpi & prev_gpi;

    assign irq = |(rising & rise_mask) || |(falling & fall_mask);

endmodule

// File: hdl/timer.sv
`timescale 1ns/10ps

module timer #(
    parameter logic [bus_pkg::addr_width-1:0] base_addr = 16'hFF10
) (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::periph_bus_t bus,
    output logic [7:0]           rdata,
    output logic                 irq
);

    import bus_pkg::*;
    import io_pkg::*;

    logic [addr_width-1:0] offset;
    logic                  hit;
    logic                  rd;
    logic [15:0]           reload;
    logic [15:0]           count;
    logic [7:0]            ctrl;
    logic                  enable;
    logic                  start;
    logic                  wrap;
    logic [7:0]            rd_reload_lo;
    logic [7:0]            rd_reload_hi;
    logic [7:0]            rd_ctrl;
    logic [7:0]            rd_count_lo;
    logic [7:0]            rd_count_hi;

    assign offset = bus.addr - base_addr;
    assign hit    = offset < addr_width'(io_window);
    assign rd     = hit && bus.sel && !bus.write_en;

    rw_register #(.reg_addr(reg_reload_lo), .reset_value(8'h00)) reload_lo_i (
        .clk, .reset, .bus, .hit, .rdata(rd_reload_lo), .value(reload[7:0])
    );
    rw_register #(.reg_addr(reg_reload_hi), .reset_value(8'h00)) reload_hi_i (
        .clk, .reset, .bus, .hit, .rdata(rd_reload_hi), .value(reload[15:8])
    );
    rw_register #(.reg_addr(reg_ctrl), .reset_value(8'h00)) ctrl_i (
        .clk, .reset, .bus, .hit, .rdata(rd_ctrl), .value(ctrl)
    );

    assign enable = ctrl[0];

    // Control write with enable set restarts from the reload value
    assign start = hit && bus.sel && bus.write_en
                && (bus.addr[2:0] == reg_ctrl) && bus.wdata[0];

    assign wrap = enable && (count == 16'h0000);

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= 16'h0000;
        end else if (start || wrap) begin
            count <= reload;
        end else if (enable) begin
            count <= count - 16'd1;
        end
    end

    assign irq = wrap;

    assign rd_count_lo = (rd && bus.addr[2:0] == reg_count_lo) ? count[7:0] : 8'h00;
    assign rd_count_hi = (rd && bus.addr[2:0] == reg_count_hi) ? count[15:8] : 8'h00;

    assign rdata = rd_reload_lo | rd_reload_hi | rd_ctrl | rd_count_lo | rd_count_hi;

endmodule

// File: hdl/bus_bridge.sv
`timescale 1ns/10ps

module bus_bridge (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::bus_req_t    req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output bus_pkg::bus_rsp_t    rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output bus_pkg::periph_bus_t bus,
    input  logic [7:0]           rdata
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond
    } state_t;

    state_t   state;
    bus_req_t held;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (req_valid) state <= st_access;
                st_access:  state <= st_respond;
                st_respond: if (rsp_ready) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            held <= req;
        end
        if (state == st_access) begin
            rsp.rdata     <= held.write_en ? 8'h00 : rdata;
            rsp.write_ack <= held.write_en;
        end
    end

    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_respond);

    // One strobe cycle per transaction
    assign bus.sel      = (state == st_access);
    assign bus.addr     = held.addr;
    assign bus.write_en = held.write_en;
    assign bus.wdata    = held.wdata;

endmodule

// File: hdl/io_subsystem.sv
`timescale 1ns/10ps

module io_subsystem #(
    parameter logic [bus_pkg::addr_width-1:0] gpio_base  = 16'hFF08,
    parameter logic [bus_pkg::addr_width-1:0] timer_base = 16'hFF10
) (
    input  logic                         clk,
    input  logic                         reset,
    input  bus_pkg::bus_req_t            req,
    input  logic                         req_valid,
    output logic                         req_ready,
    output bus_pkg::bus_rsp_t            rsp,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    input  logic [io_pkg::pin_width-1:0] gpi,
    output logic [io_pkg::pin_width-1:0] gpo,
    output logic                         gpio_irq,
    output logic                         timer_irq
);

    import bus_pkg::*;

    periph_bus_t bus;
    logic [7:0]  gpio_rdata;
    logic [7:0]  timer_rdata;
    logic [7:0]  periph_rdata;

    bus_bridge bus_bridge_i (
        .clk, .reset,
        .req, .req_valid, .req_ready,
        .rsp, .rsp_valid, .rsp_ready,
        .bus,
        .rdata(periph_rdata)
    );

    gpio #(.base_addr(gpio_base)) gpio_i (
        .clk, .reset, .bus,
        .rdata(gpio_rdata),
        .gpi, .gpo,
        .irq(gpio_irq)
    );

    timer #(.base_addr(timer_base)) timer_i (
        .clk, .reset, .bus,
        .rdata(timer_rdata),
        .irq(timer_irq)
    );

    // Unclaimed addresses read as zero since both sides drive zero
    assign periph_rdata = gpio_rdata | timer_rdata;

endmodule

// File: test/io_subsystem_chk.sv
`timescale 1ns/10ps

module io_subsystem_chk (
    input logic              clk,
    input logic              reset,
    input logic              req_ready,
    input bus_pkg::bus_rsp_t rsp,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input logic              sel
);

    int failures = 0;

    // No new request while a response is pending
    ready_while_rsp: assert property (@(posedge clk) disable iff (!reset)
        rsp_valid |-> !req_ready)
        else begin
            $error("req_ready is high while rsp_valid is high");
            failures++;
        end

    // Response held until taken
    rsp_held: assert property (@(posedge clk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("response changed or dropped under back-pressure");
            failures++;
        end

    sel_single: assert property (@(posedge clk) disable iff (!reset)
        sel |=> !sel)
        else begin
            $error("peripheral strobe lasted more than one cycle");
            failures++;
        end

endmodule

bind io_subsystem io_subsystem_chk chk_i (
    .clk,
    .reset,
    .req_ready,
    .rsp,
    .rsp_valid,
    .rsp_ready,
    .sel(bus.sel)
);

// File: test/io_scoreboard.sv
`timescale 1ns/10ps

module io_scoreboard (
    input  logic                         clk,
    input  logic                         reset,
    input  bus_pkg::bus_rsp_t            rsp,
    input  logic                         rsp_valid,
    input  logic                         rsp_ready,
    input  logic [io_pkg::pin_width-1:0] gpo,
    input  logic                         gpio_irq,
    input  logic                         timer_irq,
    input  logic                         exp_read,
    input  logic [7:0]                   exp_rdata,
    input  logic [io_pkg::pin_width-1:0] exp_gpo,
    input  logic                         irq_check,
    input  logic                         exp_irq,
    input  logic                         timer_on,
    input  int                           timer_period,
    output int                           errors,
    output int                           responses
);

    int         cycle;
    int         last_pulse;
    logic       seen_pulse;
    logic [7:0] want_rdata;
    logic       want_irq;

    always @(posedge clk) begin
        if (!reset) begin
            errors     = 0;
            responses  = 0;
            cycle      = 0;
            last_pulse = 0;
            seen_pulse = 1'b0;
        end else begin
            cycle++;
            // Compared at the response handshake
            if (rsp_valid && rsp_ready) begin
                responses++;
                want_rdata = exp_read ? exp_rdata : 8'h00;
                if (rsp.rdata !== want_rdata) begin
                    $display("FAIL rsp.rdata expected %h actual %h", want_rdata, rsp.rdata);
                    errors++;
                end
                if (rsp.write_ack !== !exp_read) begin
                    $display("FAIL rsp.write_ack expected %h actual %h",
                             !exp_read, rsp.write_ack);
                    errors++;
                end
                if (gpo !== exp_gpo) begin
                    $display("FAIL gpo expected %h actual %h", exp_gpo, gpo);
                    errors++;
                end
            end

            // Quiet unless an enabled edge was just driven
            want_irq = irq_check && exp_irq;
            if (gpio_irq !== want_irq) begin
                $display("FAIL gpio_irq expected %h actual %h", want_irq, gpio_irq);
                errors++;
            end

            if (timer_irq && !timer_on) begin
                $display("timer_irq pulsed while the timer should be stopped");
                errors++;
            end
            if (timer_irq && timer_on) begin
                if (seen_pulse && (cycle - last_pulse) != timer_period) begin
                    $display("FAIL timer_irq spacing expected %h actual %h",
                             timer_period, cycle - last_pulse);
                    errors++;
                end
                last_pulse = cycle;
                seen_pulse = 1'b1;
            end
            if (!timer_on) begin
                seen_pulse = 1'b0;
            end
        end
    end

endmodule

// File: test/tb_io_subsystem.sv
`timescale 1ns/10ps

module tb_io_subsystem;

    import bus_pkg::*;
    import io_pkg::*;

    localparam logic [15:0] gpio_base  = 16'hFF08;
    localparam logic [15:0] timer_base = 16'hFF10;
    localparam int          wait_limit = 100;

    localparam logic [1:0] op_write = 2'd0;
    localparam logic [1:0] op_read  = 2'd1;
    localparam logic [1:0] op_gpi   = 2'd2;
    localparam logic [1:0] op_timer = 2'd3;

    // data is the write byte, the gpi value or the pulse count
    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [7:0]  exp_data;
        logic        exp_irq;
    } row_t;

    logic                 clk;
    logic                 reset;
    bus_req_t             req;
    logic                 req_valid;
    logic                 req_ready;
    bus_rsp_t             rsp;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [pin_width-1:0] gpi;
    logic [pin_width-1:0] gpo;
    logic                 gpio_irq;
    logic                 timer_irq;

    // Expectations for the scoreboard
    logic                 exp_read;
    logic [7:0]           exp_rdata;
    logic [pin_width-1:0] exp_gpo;
    logic                 irq_check;
    logic                 exp_irq;
    logic                 timer_on;
    int                   timer_period;

    logic [15:0] reload;
    logic [31:0] lfsr;
    row_t        rows[$];
    int          errors;
    int          responses;
    int          issued;
    int          timeouts;
    int          assert_fails;

    io_subsystem #(.gpio_base(gpio_base), .timer_base(timer_base)) io_subsystem_i (
        .clk, .reset, .req, .req_valid, .req_ready, .rsp, .rsp_valid, .rsp_ready,
        .gpi, .gpo, .gpio_irq, .timer_irq
    );

    io_scoreboard io_scoreboard_i (
        .clk, .reset, .rsp, .rsp_valid, .rsp_ready, .gpo, .gpio_irq, .timer_irq,
        .exp_read, .exp_rdata, .exp_gpo, .irq_check, .exp_irq, .timer_on,
        .timer_period, .errors, .responses
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] gpio_addr(input logic [2:0] off);
        return {gpio_base[15:3], off};
    endfunction

    function automatic logic [15:0] timer_addr(input logic [2:0] off);
        return {timer_base[15:3], off};
    endfunction

    function automatic row_t make_row(input logic [1:0] op, input logic [15:0] addr,
                                      input logic [15:0] data, input logic [7:0] exp_data,
                                      input logic irq);
        return '{op, addr, data, exp_data, irq};
    endfunction

    task automatic build_table();
        for (int i = 0; i < io_window; i++) begin
            rows.push_back(make_row(op_read, gpio_addr(3'(i)), 16'h0000,
                                    (i == int'(reg_gpi_hi)) ? 8'h5A : 8'h00, 1'b0));
        end
        for (int i = 0; i < io_window; i++) begin
            rows.push_back(make_row(op_read, timer_addr(3'(i)), 16'h0000, 8'h00, 1'b0));
        end
        rows.push_back(make_row(op_write, gpio_addr(reg_gpo_lo), 16'h003C, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, gpio_addr(reg_gpo_hi), 16'h00A5, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_gpo_lo), 16'h0000, 8'h3C, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_gpo_hi), 16'h0000, 8'hA5, 1'b0));
        rows.push_back(make_row(op_gpi, 16'h0000, 16'h1234, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_gpi_lo), 16'h0000, 8'h34, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_gpi_hi), 16'h0000, 8'h12, 1'b0));
        // Rise mask on bit 0, fall mask on bit 15
        rows.push_back(make_row(op_write, gpio_addr(reg_rise_lo), 16'h0001, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, gpio_addr(reg_fall_hi), 16'h0080, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_rise_lo), 16'h0000, 8'h01, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_fall_hi), 16'h0000, 8'h80, 1'b0));
        rows.push_back(make_row(op_gpi, 16'h0000, 16'h1235, 8'h00, 1'b1));
        rows.push_back(make_row(op_gpi, 16'h0000, 16'h1234, 8'h00, 1'b0));
        rows.push_back(make_row(op_gpi, 16'h0000, 16'h9234, 8'h00, 1'b0));
        rows.push_back(make_row(op_gpi, 16'h0000, 16'h1234, 8'h00, 1'b1));
        // Reload 11, so pulses come 12 cycles apart
        rows.push_back(make_row(op_write, timer_addr(reg_reload_lo), 16'h000B, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, timer_addr(reg_reload_hi), 16'h0000, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, timer_addr(reg_ctrl), 16'h0001, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, timer_addr(reg_ctrl), 16'h0000, 8'h01, 1'b0));
        rows.push_back(make_row(op_timer, 16'h0000, 16'h0003, 8'h00, 1'b0));
        // Stopped right after a wrap, one decrement past the reload
        rows.push_back(make_row(op_write, timer_addr(reg_ctrl), 16'h0000, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, timer_addr(reg_count_lo), 16'h0000, 8'h0A, 1'b0));
        rows.push_back(make_row(op_read, timer_addr(reg_count_lo), 16'h0000, 8'h0A, 1'b0));
        rows.push_back(make_row(op_read, timer_addr(reg_count_hi), 16'h0000, 8'h00, 1'b0));
        // Outside both windows
        rows.push_back(make_row(op_read, 16'hFF00, 16'h0000, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, 16'hFF18, 16'h00FF, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, 16'hFF18, 16'h0000, 8'h00, 1'b0));
        rows.push_back(make_row(op_write, 16'hFF07, 16'h0077, 8'h00, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_fall_hi), 16'h0000, 8'h80, 1'b0));
        rows.push_back(make_row(op_read, gpio_addr(reg_gpo_lo), 16'h0000, 8'h3C, 1'b0));
        rows.push_back(make_row(op_read, timer_addr(reg_reload_lo), 16'h0000, 8'h0B, 1'b0));
    endtask

    // Register model for the expected gpo and pulse spacing
    task automatic track_write(input row_t r);
        if (r.addr == gpio_addr(reg_gpo_lo)) begin
            exp_gpo[7:0] = r.data[7:0];
        end
        if (r.addr == gpio_addr(reg_gpo_hi)) begin
            exp_gpo[15:8] = r.data[7:0];
        end
        if (r.addr == timer_addr(reg_reload_lo)) begin
            reload[7:0] = r.data[7:0];
        end
        if (r.addr == timer_addr(reg_reload_hi)) begin
            reload[15:8] = r.data[7:0];
        end
        timer_period = int'(reload) + 1;
    endtask

    task automatic apply_access(input row_t r, input int index);
        int         waited;
        logic [1:0] delay;
        req.addr     = r.addr;
        req.write_en = (r.op == op_write);
        req.wdata    = r.data[7:0];
        exp_read     = (r.op == op_read);
        exp_rdata    = r.exp_data;
        if (r.op == op_write) begin
            track_write(r);
        end
        req_valid = 1'b1;
        issued++;
        waited = 0;
        while (!req_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("Row %0d: the request was never accepted", index);
            timeouts++;
            req_valid = 1'b0;
            return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        waited = 0;
        while (!rsp_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            $display("Row %0d: no response arrived", index);
            timeouts++;
            return;
        end
        lfsr     = lfsr_step(lfsr);
        delay[0] = lfsr[0];
        lfsr     = lfsr_step(lfsr);
        delay[1] = lfsr[0];
        repeat (delay) @(negedge clk);
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        if (r.op == op_write && r.addr == timer_addr(reg_ctrl)) begin
            timer_on = r.data[0];
        end
    endtask

    task automatic apply_gpi(input row_t r);
        gpi       = r.data;
        exp_irq   = r.exp_irq;
        irq_check = 1'b1;
        @(negedge clk);
        irq_check = 1'b0;
    endtask

    // Returns on the falling edge where the last pulse is seen
    task automatic wait_timer_pulses(input row_t r, input int index);
        int pulses;
        int waited;
        pulses = 0;
        waited = 0;
        while (pulses < int'(r.data) && waited < wait_limit) begin
            @(negedge clk);
            waited++;
            if (timer_irq) begin
                pulses++;
            end
        end
        if (pulses < int'(r.data)) begin
            $display("Row %0d: timer pulses stopped coming", index);
            timeouts++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        gpi          = 16'h5A00;
        exp_read     = 1'b0;
        exp_rdata    = 8'h00;
        exp_gpo      = '0;
        irq_check    = 1'b0;
        exp_irq      = 1'b0;
        timer_on     = 1'b0;
        timer_period = 1;
        reload       = 16'h0000;
        lfsr         = 32'h5ada;
        issued       = 0;
        timeouts     = 0;
        build_table();
        repeat (5) @(negedge clk);
        reset = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            case (rows[i].op)
                op_gpi:   apply_gpi(rows[i]);
                op_timer: wait_timer_pulses(rows[i], i);
                default:  apply_access(rows[i], i);
            endcase
        end
        @(negedge clk);

        assert_fails = io_subsystem_i.chk_i.failures;
        if (responses != issued) begin
            $display("Response count does not match the number of requests");
        end
        $display("Summary: %0d requests, %0d responses, %0d check errors, %0d timeouts, %0d %s",
                 issued, responses, errors, timeouts, assert_fails, "assertion failures");
        if (errors == 0 && timeouts == 0 && assert_fails == 0 && responses == issued) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/bus_pkg.sv
hdl/io_pkg.sv
hdl/rw_register.sv
hdl/gpio.sv
hdl/timer.sv
hdl/bus_bridge.sv
hdl/io_subsystem.sv
test/io_subsystem_chk.sv
test/io_scoreboard.sv
test/tb_io_subsystem.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --assert --top-module tb_io_subsystem -f compile.f -Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module tb_io_subsystem -f compile.f

clean:
	rm -rf obj_dir sim.log
